// ==== hub75_matrix.f ====
+incdir+source
source/hub75_matrix_pkg.sv
source/scan_if.sv
source/command_decoder.sv
source/framebuffer.sv
source/framebuffer_fetch.sv
source/pixel_split.sv
source/matrix_scan.sv
source/hub75_matrix.sv
dv/clock_gen.sv
dv/tb_hub75_matrix.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the hub75 matrix testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing --assert --top-module tb_hub75_matrix \
    -f hub75_matrix.f > "$log" 2>&1 \
    && ./obj_dir/Vtb_hub75_matrix >> "$log" 2>&1 \
    || echo "Test failed" >> "$log"
cat "$log"
# a build error, a crash or a failing check all leave the fail line in the log
grep -q "Test failed" "$log" && exit 1 || exit 0

// ==== dv/tb_hub75_matrix.sv ====
// ==================================================
// hub75 matrix testbench
// random frames over the command port against a panel model
// ==================================================
`include "hub75_matrix_cfg.svh"

module tb_hub75_matrix import hub75_matrix_pkg::*; ();

    localparam int COLS = `PANEL_COLS;
    localparam int HALF_ROWS = `PANEL_ROWS / 2;
    localparam int PLANES = `COLOR_BITS;
    localparam int NUM_PIXELS = `PANEL_ROWS * `PANEL_COLS;
    // shift, latch and blank per row pair and plane, plus the binary lit time
    localparam int FRAME_CYCLES = HALF_ROWS * (PLANES * (COLS * `PIXEL_TICKS + 2)
                                  + `OE_BASE_TICKS * ((1 << PLANES) - 1));
    localparam int WRITE_CYCLES = NUM_PIXELS * 5 * 2;  // five bytes each with a gap before every byte
    localparam int TIMEOUT_CYCLES = WRITE_CYCLES + 4 * 3 * FRAME_CYCLES;  // four checked frames

    logic           clk_root;
    logic           rst_n;
    logic [7:0]     cmd_data;
    logic           cmd_valid;
    rgb_t           rgb_top;
    rgb_t           rgb_bottom;
    row_pair_addr_t row_addr;
    logic           clk_pixel;
    logic           row_latch;
    logic           oe_n;

    pixel_t       model_mem [NUM_PIXELS];  // index {row, col}
    color_level_t model_planes;
    rgb_t         model_channels;

    rgb_t col_top [COLS];     // shifted data of the current row
    rgb_t col_bottom [COLS];
    int   shift_count;
    int   latch_count;
    int   frame_starts;
    int   check_latches;      // latches still to compare
    int   oe_low_cycles;
    int   oe_expected;
    logic oe_was_low;
    int   error_count;
    int   check_count;
    int   cycle_count;

    clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) u_clock_gen (
        .clk_root (clk_root),
        .rst_n    (rst_n)
    );

    hub75_matrix UUT (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .cmd_data   (cmd_data),
        .cmd_valid  (cmd_valid),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .row_addr   (row_addr),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n)
    );

    // bit of each channel at this plane, masked by both enables
    function automatic rgb_t expected_rgb(input int half, input int pair, input int col,
                                          input int plane);
        pixel_t pix;
        rgb_t   bits;
        pix = model_mem[(half * HALF_ROWS + pair) * COLS + col];
        bits[2] = pix[2 * PLANES + plane];  // red
        bits[1] = pix[PLANES + plane];
        bits[0] = pix[plane];
        if (!model_planes[plane]) begin
            bits = '0;
        end
        return bits & model_channels;
    endfunction

    task automatic compare_row(input int pair, input int plane);
        rgb_t exp_top;
        rgb_t exp_bottom;
        for (int c = 0; c < COLS; c++) begin
            exp_top    = expected_rgb(0, pair, c, plane);
            exp_bottom = expected_rgb(1, pair, c, plane);
            check_count += 2;
            assert (col_top[c] == exp_top && col_bottom[c] == exp_bottom) else begin
                error_count++;
                $display("Error at %0t: row pair %0d plane %0d column %0d top %b/%b bottom %b/%b",
                         $time, pair, plane, c, col_top[c], exp_top, col_bottom[c], exp_bottom);
            end
        end
    endtask

    task automatic handle_latch;
        int plane;
        int pair_expected;
        plane = latch_count % PLANES;
        pair_expected = (latch_count / PLANES) % HALF_ROWS;
        check_count++;
        assert (shift_count == COLS && int'(row_addr) == pair_expected) else begin
            error_count++;
            $display("Error at %0t: latch after %0d columns on row %0d, expected %0d on row %0d",
                     $time, shift_count, row_addr, COLS, pair_expected);
        end
        if (check_latches > 0) begin
            compare_row(pair_expected, plane);
            check_latches--;
        end
        if (pair_expected == 0 && plane == 0) begin
            frame_starts++;
        end
        oe_expected = `OE_BASE_TICKS << plane;
        latch_count++;
        shift_count = 0;
    endtask

    task automatic measure_display;
        if (!oe_n) begin
            oe_low_cycles++;
        end else if (oe_was_low) begin
            check_count++;
            assert (oe_low_cycles == oe_expected) else begin
                error_count++;
                $display("Error at %0t: panel lit for %0d cycles, expected %0d",
                         $time, oe_low_cycles, oe_expected);
            end
            oe_low_cycles = 0;
        end
        oe_was_low = !oe_n;
    endtask

    // panel side sampled half a cycle away from the DUT edges
    always @(negedge clk_root) begin
        if (!rst_n) begin
            shift_count   = 0;
            latch_count   = 0;
            frame_starts  = 0;
            oe_low_cycles = 0;
            oe_was_low    = 1'b0;
        end else begin
            assert (oe_n || (latch_count > 0 && !clk_pixel)) else begin
                error_count++;
                $display("Error at %0t: oe_n low before the first latch or while shifting", $time);
            end
            if (clk_pixel) begin
                if (shift_count < COLS) begin
                    col_top[shift_count]    = rgb_top;
                    col_bottom[shift_count] = rgb_bottom;
                end
                shift_count++;
            end
            if (row_latch) begin
                handle_latch();
            end
            measure_display();
        end
    end

    task automatic report_counts;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
    endtask

    always @(posedge clk_root) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    // one byte per strobe with now and then an idle cycle of junk on the bus
    task automatic send_byte(input logic [7:0] value);
        if ($urandom_range(0, 3) == 0) begin
            @(posedge clk_root);
            #1;
            cmd_valid = 1'b0;
            cmd_data  = 8'($urandom);
        end
        @(posedge clk_root);
        #1;
        cmd_data  = value;
        cmd_valid = 1'b1;
    endtask

    task automatic end_bytes;
        @(posedge clk_root);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic fill_framebuffer;
        pixel_t pix;
        for (int a = 0; a < NUM_PIXELS; a++) begin
            pix = 12'($urandom);
            send_byte(`CMD_PIXEL);
            send_byte(8'(a % COLS));
            send_byte(8'(a / COLS));
            send_byte({4'($urandom), pix[11:8]});  // upper nibble is don't care
            send_byte(pix[7:0]);
            model_mem[a] = pix;
        end
        end_bytes();
    endtask

    task automatic set_enables(input color_level_t planes, input rgb_t channels);
        send_byte(`CMD_BRIGHT);
        send_byte({4'($urandom), planes});
        send_byte(`CMD_COLOR);
        send_byte({5'($urandom), channels});
        end_bytes();
        model_planes   = planes;
        model_channels = channels;
    endtask

    task automatic send_unknown_bytes(input int count);
        logic [7:0] b;
        for (int i = 0; i < count; i++) begin
            do begin
                b = 8'($urandom);
            end while (b == `CMD_PIXEL || b == `CMD_BRIGHT || b == `CMD_COLOR);
            send_byte(b);
        end
        end_bytes();
    endtask

    // compare every row pair and plane after the next frame start
    task automatic check_next_frame;
        int starts_seen;
        starts_seen = frame_starts;
        wait (frame_starts != starts_seen);
        check_latches = PLANES * HALF_ROWS;
        wait (check_latches == 0);
    endtask

    initial begin
        cmd_data       = '0;
        cmd_valid      = 1'b0;
        error_count    = 0;
        check_count    = 0;
        cycle_count    = 0;
        check_latches  = 0;
        model_planes   = '1;
        model_channels = '1;
        void'($urandom(32'h62ff_be72));
        wait (rst_n === 1'b1);
        check_count++;
        assert (oe_n && !clk_pixel && !row_latch && row_addr == '0) else begin
            error_count++;
            $display("Error at %0t: panel pins not idle after reset", $time);
        end
        fill_framebuffer();
        check_next_frame();
        set_enables(color_level_t'($urandom_range(1, 14)), model_channels);
        check_next_frame();
        set_enables('1, rgb_t'($urandom_range(1, 6)));  // all planes back on
        check_next_frame();
        send_unknown_bytes(24);
        check_next_frame();
        report_counts();
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dv/clock_gen.sv ====
// ==================================================
// testbench clock and reset generator
// ==================================================
module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_root,
    output logic rst_n
);

    initial begin
        clk_root = 1'b0;
        forever begin
            #(PERIOD / 2) clk_root = ~clk_root;
        end
    end

    // released just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_root);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== source/hub75_matrix.sv ====
// ==================================================
// hub75 matrix top
// command stream in, HUB75 panel signals out
// ==================================================
module hub75_matrix import hub75_matrix_pkg::*; (
    input  logic           clk_root,
    input  logic           rst_n,
    input  logic [7:0]     cmd_data,
    input  logic           cmd_valid,
    output rgb_t           rgb_top,
    output rgb_t           rgb_bottom,
    output row_pair_addr_t row_addr,
    output logic           clk_pixel,
    output logic           row_latch,
    output logic           oe_n
);

    // decoder to framebuffer
    pixel_addr_t  wr_addr;
    pixel_t       wr_data;
    logic         wr_en;
    color_level_t plane_enable;
    rgb_t         channel_enable;

    // fetch to framebuffer
    logic [$bits(row_pair_addr_t)+$bits(col_addr_t)-1:0] rd_addr;
    logic         rd_en;
    pixel_pair_t  rd_data;

    pixel_t       pixels [2];     // index 0 top, 1 bottom
    rgb_t         rgb_split [2];

    scan_if scan_bus ();

    command_decoder u_decoder (
        .clk_root       (clk_root),
        .rst_n          (rst_n),
        .cmd_data       (cmd_data),
        .cmd_valid      (cmd_valid),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_en          (wr_en),
        .plane_enable   (plane_enable),
        .channel_enable (channel_enable)
    );

    framebuffer u_framebuffer (
        .clk_root (clk_root),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_data  (rd_data)
    );

    framebuffer_fetch u_fetch (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .scan     (scan_bus.fetch),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .pixels   (pixels)
    );

    // one splitter per panel half
    for (genvar half = 0; half < 2; half++) begin : g_split
        pixel_split u_split (
            .pixel          (pixels[half]),
            .plane          (scan_bus.plane),
            .plane_enable   (plane_enable),
            .channel_enable (channel_enable),
            .rgb            (rgb_split[half])
        );
    end

    matrix_scan u_scan (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .scan       (scan_bus.scan),
        .rgb_in     (rgb_split),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .row_addr   (row_addr),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n)
    );

endmodule

// ==== source/matrix_scan.sv ====
// ==================================================
// matrix scan
// shifts columns, latches rows, times output enable
// ==================================================
`include "hub75_matrix_cfg.svh"

module matrix_scan import hub75_matrix_pkg::*; (
    input  logic           clk_root,
    input  logic           rst_n,
    scan_if.scan           scan,
    input  rgb_t           rgb_in [2],
    output rgb_t           rgb_top,
    output rgb_t           rgb_bottom,
    output row_pair_addr_t row_addr,
    output logic           clk_pixel,
    output logic           row_latch,
    output logic           oe_n
);

    localparam int TICK_W = $clog2(`PIXEL_TICKS);
    localparam int OE_MAX = `OE_BASE_TICKS << (`COLOR_BITS - 1);
    localparam int OE_W = $clog2(OE_MAX);

    scan_state_t       state;
    logic [TICK_W-1:0] tick;      // cycle within one column
    logic [OE_W-1:0]   oe_count;  // display cycles left
    logic              last_tick;
    logic              last_col;
    logic              last_plane;

    assign last_tick  = tick == TICK_W'(`PIXEL_TICKS - 1);
    assign last_col   = scan.column == col_addr_t'(`PANEL_COLS - 1);
    assign last_plane = scan.plane == bit_plane_t'(`COLOR_BITS - 1);

    // fetch request in the first cycle of each column
    assign scan.load = (state == shift) && (tick == '0);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state         <= shift;
            tick          <= '0;
            oe_count      <= '0;
            scan.column   <= '0;
            scan.row_pair <= '0;
            scan.plane    <= '0;
            rgb_top       <= '0;
            rgb_bottom    <= '0;
            row_addr      <= '0;
            clk_pixel     <= 1'b0;
            row_latch     <= 1'b0;
            oe_n          <= 1'b1;
        end else begin
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            case (state)
                shift: begin
                    tick <= tick + 1'b1;
                    // split result is valid two cycles after load
                    if (tick == TICK_W'(`PIXEL_TICKS - 2)) begin
                        rgb_top    <= rgb_in[0];
                        rgb_bottom <= rgb_in[1];
                        clk_pixel  <= 1'b1;  // rises with the data, high in last tick
                    end
                    if (last_tick) begin
                        tick <= '0;
                        if (last_col) begin
                            scan.column <= '0;
                            row_latch   <= 1'b1;
                            row_addr    <= scan.row_pair;  // switches with the latch
                            state       <= latch;
                        end else begin
                            scan.column <= scan.column + 1'b1;
                        end
                    end
                end
                latch: begin
                    // binary weight of this plane, counted down to zero
                    oe_count <= OE_W'((`OE_BASE_TICKS << scan.plane) - 1);
                    oe_n     <= 1'b0;
                    state    <= display;
                end
                display: begin
                    if (oe_count == '0) begin
                        oe_n  <= 1'b1;
                        state <= blank;
                    end else begin
                        oe_count <= oe_count - 1'b1;
                    end
                end
                blank: begin
                    scan.plane <= scan.plane + 1'b1;
                    if (last_plane) begin
                        scan.row_pair <= scan.row_pair + 1'b1;  // wraps after the last pair
                    end
                    state <= shift;
                end
                default: state <= shift;
            endcase
        end
    end

endmodule

// ==== source/pixel_split.sv ====
// ==================================================
// pixel split
// current bit plane of one pixel, masked by enables
// ==================================================
module pixel_split import hub75_matrix_pkg::*; (
    input  pixel_t       pixel,
    input  bit_plane_t   plane,
    input  color_level_t plane_enable,
    input  rgb_t         channel_enable,
    output rgb_t         rgb
);

    color_level_t red;
    color_level_t green;
    color_level_t blue;
    logic         plane_on;

    assign {red, green, blue} = pixel;
    assign plane_on = plane_enable[plane];  // whole plane blanked when off

    // one bit per channel at this plane
    assign rgb = {red[plane], green[plane], blue[plane]} & channel_enable & {3{plane_on}};

endmodule

// ==== source/framebuffer_fetch.sv ====
// ==================================================
// framebuffer fetch
// turns a scan request into a read, holds the pair
// ==================================================
module framebuffer_fetch import hub75_matrix_pkg::*; (
    input  logic        clk_root,
    input  logic        rst_n,
    scan_if.fetch       scan,
    output logic [$bits(row_pair_addr_t)+$bits(col_addr_t)-1:0] rd_addr,
    output logic        rd_en,
    input  pixel_pair_t rd_data,
    output pixel_t      pixels [2]
);

    localparam int PIX_W = $bits(pixel_t);

    logic load_q;  // read data is back this cycle

    // request goes out in the load cycle itself
    assign rd_en   = scan.load;
    assign rd_addr = {scan.row_pair, scan.column};

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= scan.load;
        end
    end

    // split the pair by half, held until the next load
    always_ff @(posedge clk_root) begin
        if (load_q) begin
            pixels[0] <= rd_data[2*PIX_W-1:PIX_W];  // top
            pixels[1] <= rd_data[PIX_W-1:0];        // bottom
        end
    end

endmodule

// ==== source/framebuffer.sv ====
// ==================================================
// framebuffer
// two banks, pixel-wide write, row-pair-wide read
// ==================================================
module framebuffer import hub75_matrix_pkg::*; (
    input  logic        clk_root,
    input  pixel_addr_t wr_addr,
    input  pixel_t      wr_data,
    input  logic        wr_en,
    input  logic [$bits(row_pair_addr_t)+$bits(col_addr_t)-1:0] rd_addr,
    input  logic        rd_en,
    output pixel_pair_t rd_data
);

    localparam int RD_W = $bits(row_pair_addr_t) + $bits(col_addr_t);
    localparam int DEPTH = 1 << RD_W;
    localparam int HALF_BIT = $bits(pixel_addr_t) - 1;  // top row bit picks the bank

    // bank 0 is the top half, bank 1 the bottom half
    pixel_t bank [2][DEPTH];

    logic                 wr_bank;
    logic [RD_W-1:0]      wr_index;

    assign wr_bank  = wr_addr[HALF_BIT];
    assign wr_index = wr_addr[RD_W-1:0];

    // write port
    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            bank[wr_bank][wr_index] <= wr_data;
        end
    end

    // read port, both halves at once
    always_ff @(posedge clk_root) begin
        if (rd_en) begin
            rd_data <= {bank[0][rd_addr], bank[1][rd_addr]};  // top above bottom
        end
    end

endmodule

// ==== source/command_decoder.sv ====
// ==================================================
// command decoder
// parses command bytes into pixel writes and enables
// ==================================================
`include "hub75_matrix_cfg.svh"

module command_decoder import hub75_matrix_pkg::*; (
    input  logic         clk_root,
    input  logic         rst_n,
    input  logic [7:0]   cmd_data,
    input  logic         cmd_valid,
    output pixel_addr_t  wr_addr,
    output pixel_t       wr_data,
    output logic         wr_en,
    output color_level_t plane_enable,
    output rgb_t         channel_enable
);

    localparam int COL_W = $bits(col_addr_t);
    localparam int ADDR_W = $bits(pixel_addr_t);
    localparam int ROW_W = ADDR_W - COL_W;
    localparam int PIX_W = $bits(pixel_t);

    cmd_state_t state;

    // control path
    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state          <= idle;
            wr_en          <= 1'b0;
            plane_enable   <= '1;  // all planes shown
            channel_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (cmd_valid) begin
                case (state)
                    idle: begin
                        case (cmd_data)
                            `CMD_PIXEL:  state <= get_x;
                            `CMD_BRIGHT: state <= get_bright;
                            `CMD_COLOR:  state <= get_color;
                            default:     state <= idle;  // unknown bytes dropped
                        endcase
                    end
                    get_x:  state <= get_y;
                    get_y:  state <= get_hi;
                    get_hi: state <= get_lo;
                    get_lo: begin
                        wr_en <= 1'b1;  // write lands the cycle after the low byte
                        state <= idle;
                    end
                    get_bright: begin
                        plane_enable <= cmd_data[$bits(color_level_t)-1:0];
                        state        <= idle;
                    end
                    get_color: begin
                        channel_enable <= cmd_data[$bits(rgb_t)-1:0];
                        state          <= idle;
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // operand capture straight into the write port fields
    always_ff @(posedge clk_root) begin
        if (cmd_valid) begin
            case (state)
                get_x:   wr_addr[COL_W-1:0] <= cmd_data[COL_W-1:0];
                get_y:   wr_addr[ADDR_W-1:COL_W] <= cmd_data[ROW_W-1:0];
                get_hi:  wr_data[PIX_W-1:8] <= cmd_data[PIX_W-9:0];  // red nibble
                get_lo:  wr_data[7:0] <= cmd_data;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/scan_if.sv ====
// ==================================================
// scan request link
// column, row pair and plane with a load strobe
// ==================================================
interface scan_if import hub75_matrix_pkg::*; ();

    col_addr_t      column;    // column being shifted
    row_pair_addr_t row_pair;  // row within each half
    bit_plane_t     plane;     // plane being shown
    logic           load;      // one-cycle fetch request

    // scan engine side
    modport scan (
        output column,
        output row_pair,
        output plane,
        output load
    );

    // fetch side
    modport fetch (
        input column,
        input row_pair,
        input plane,
        input load
    );

endinterface

// ==== source/hub75_matrix_pkg.sv ====
// ==================================================
// hub75 matrix types
// widths and state encodings shared by the design
// ==================================================
`include "hub75_matrix_cfg.svh"

package hub75_matrix_pkg;

    typedef logic [$clog2(`PANEL_COLS)-1:0] col_addr_t;
    typedef logic [$clog2(`PANEL_ROWS / 2)-1:0] row_pair_addr_t;  // also panel row lines
    typedef logic [$clog2(`PANEL_ROWS)+$clog2(`PANEL_COLS)-1:0] pixel_addr_t;  // {row, col}

    typedef logic [`COLOR_BITS-1:0] color_level_t;  // also plane enable mask
    typedef logic [3*`COLOR_BITS-1:0] pixel_t;      // red high, blue low
    typedef logic [6*`COLOR_BITS-1:0] pixel_pair_t; // top half above bottom half
    typedef logic [$clog2(`COLOR_BITS)-1:0] bit_plane_t;
    typedef logic [2:0] rgb_t;                      // one bit per channel, red high

    // command byte parser
    typedef enum logic [2:0] {
        idle,
        get_x,
        get_y,
        get_hi,
        get_lo,
        get_bright,
        get_color
    } cmd_state_t;

    // panel scan sequence
    typedef enum logic [1:0] {
        shift,
        latch,
        display,
        blank
    } scan_state_t;

endpackage

// ==== source/hub75_matrix_cfg.svh ====
// ==================================================
// hub75 matrix configuration
// panel geometry, scan timing and command opcodes
// ==================================================
`ifndef HUB75_MATRIX_CFG_SVH
`define HUB75_MATRIX_CFG_SVH

// panel geometry
`define PANEL_COLS 16       // columns per row
`define PANEL_ROWS 8        // two halves of 4 rows each
`define COLOR_BITS 4        // bits per colour channel

// scan timing in clk_root cycles
`define PIXEL_TICKS 4       // per shifted column
`define OE_BASE_TICKS 8     // lit time of plane 0, doubles per plane

// command opcodes
`define CMD_PIXEL 8'h50     // x, y, hi, lo
`define CMD_BRIGHT 8'h42    // plane enable mask
`define CMD_COLOR 8'h43     // channel enable mask

`endif
